/* verilog/usb_pid_pkg.sv */
package usb_pid_pkg;

  // Token kinds as delivered by the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_e;

  // Handshake kinds, STALL and NYET are not used here
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_e;

  // Data packet kinds, no high-speed DATA2/MDATA on a full-speed device
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_e;

  // Received token, address and endpoint ride along but are not filtered
  typedef struct packed {
    logic       recv;
    tok_type_e  kind;
    logic [6:0] addr;
    logic [3:0] endp;
  } tok_s;

  // Received handshake
  typedef struct packed {
    logic      recv;
    hsk_type_e kind;
  } hsk_rx_s;

  // Header of a received data packet, payload follows on the byte stream
  typedef struct packed {
    logic      recv;
    data_pid_e kind;
  } data_rx_s;

  // One stream beat, the ready travels on its own wire
  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } byte_stream_s;

endpackage

/* verilog/ctl_xfer_pkg.sv */
package ctl_xfer_pkg;

  import usb_pid_pkg::*;

  // SETUP payload is always eight bytes
  localparam int SETUP_BYTES = 8;
  localparam int SETUP_PTR_W = 3;

  // Stages of one control transfer
  typedef enum logic [3:0] {
    CTL_DONE       = 4'h0,
    CTL_SETUP_RX   = 4'h1,
    CTL_SETUP_ACK  = 4'h2,
    CTL_DATA_TOK   = 4'h3,
    CTL_DATO_RX    = 4'h4,
    CTL_DATO_ACK   = 4'h5,
    CTL_DATI_TX    = 4'h6,
    CTL_DATI_ACK   = 4'h7,
    CTL_STATUS_TOK = 4'h8,
    CTL_STATUS_RX  = 4'h9,
    CTL_STATUS_TX  = 4'ha,
    CTL_STATUS_ACK = 4'hb
  } ctl_stage_e;

  // Decoded SETUP request, multi-byte fields are little-endian on the wire
  typedef struct packed {
    logic [7:0]  rtype;
    logic [7:0]  request;
    logic [15:0] value;
    logic [15:0] index;
    logic [15:0] length;
  } setup_req_s;

  // Single-cycle send request from the stage FSM
  typedef struct packed {
    logic      hsk_req;
    logic      data_req;
    logic      zero_len;
    data_pid_e kind;
  } pkt_req_s;

endpackage

/* verilog/setup_parser.sv */
`timescale 1ns/1ns

module setup_parser import usb_pid_pkg::*, ctl_xfer_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         fsm_idle_i,
  input  logic         setup_active_i,
  input  byte_stream_s usb_rx_i,
  input  byte_stream_s ctl_tx_i,
  input  logic         ctl_tready_i,
  output setup_req_s   req_o,
  output logic         start_o,
  output logic         cycle_o
);

  logic [SETUP_PTR_W-1:0] ptr_q;
  setup_req_s             req_q;
  logic                   start_q;
  logic                   cycle_q;
  logic                   rx_take;
  logic                   last_byte;
  logic                   tx_done;

  // Receive stream is never stalled, so valid alone moves a byte
  assign rx_take   = setup_active_i && usb_rx_i.valid;
  assign last_byte = ptr_q == SETUP_PTR_W'(SETUP_BYTES - 1);
  // Handler finished its IN data
  assign tx_done   = ctl_tx_i.valid && ctl_tready_i && ctl_tx_i.last;

  always_ff @(posedge clock) begin
    if (reset) begin
      ptr_q   <= '0;
      req_q   <= '0;
      start_q <= 1'b0;
      cycle_q <= 1'b0;
    end else if (fsm_idle_i) begin
      // Bus idle, get ready for the next SETUP
      ptr_q        <= '0;
      req_q.length <= '0;
      start_q      <= 1'b0;
      cycle_q      <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (rx_take) begin
        // Steer byte into its field
        case (ptr_q)
          3'd0: req_q.rtype         <= usb_rx_i.data;
          3'd1: req_q.request       <= usb_rx_i.data;
          3'd2: req_q.value[7:0]    <= usb_rx_i.data;
          3'd3: req_q.value[15:8]   <= usb_rx_i.data;
          3'd4: req_q.index[7:0]    <= usb_rx_i.data;
          3'd5: req_q.index[15:8]   <= usb_rx_i.data;
          3'd6: req_q.length[7:0]   <= usb_rx_i.data;
          default: req_q.length[15:8] <= usb_rx_i.data;
        endcase
        if (last_byte) begin
          // Request complete, hand it to the handler
          start_q <= 1'b1;
          cycle_q <= 1'b1;
        end else begin
          ptr_q <= ptr_q + 1'b1;
        end
      end else if (tx_done) begin
        cycle_q <= 1'b0;
      end
    end
  end

  assign req_o   = req_q;
  assign start_o = start_q;
  assign cycle_o = cycle_q;

endmodule

/* verilog/ctl_stage_fsm.sv */
`timescale 1ns/1ns

module ctl_stage_fsm import usb_pid_pkg::*, ctl_xfer_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         fsm_ctrl_i,
  input  logic         fsm_idle_i,
  input  setup_req_s   req_i,
  input  tok_s         tok_i,
  input  hsk_rx_s      hsk_rx_i,
  input  logic         hsk_sent_i,
  input  data_rx_s     data_rx_i,
  input  byte_stream_s usb_rx_i,
  input  byte_stream_s ctl_tx_i,
  input  logic         ctl_tready_i,
  input  logic         data_taken_i,
  output logic         setup_active_o,
  output logic         stage_done_o,
  output pkt_req_s     pkt_req_o
);

  ctl_stage_e stage_q;
  ctl_stage_e stage_d;
  logic       data_recv_q;
  data_pid_e  data_kind_q;
  logic       odd_q;
  logic       out_seen_q;
  logic       tx_issued_q;
  logic       rx_beat_end;
  logic       rx_zero_end;
  logic       rx_end;
  logic       rx_stage;
  logic       tx_last;
  logic       tok_in;
  logic       tok_out;
  pkt_req_s   pkt_req;

  // Recv pulse delayed by one so it lines up with a bare last
  always_ff @(posedge clock) begin
    if (reset) begin
      data_recv_q <= 1'b0;
    end else if (data_rx_i.recv) begin
      data_recv_q <= 1'b1;
    end else if (usb_rx_i.valid || usb_rx_i.last) begin
      data_recv_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (data_rx_i.recv) begin
      data_kind_q <= data_rx_i.kind;
    end
  end

  assign rx_beat_end = usb_rx_i.valid && usb_rx_i.last;
  // Last without data right after recv means an empty DATA1
  assign rx_zero_end = data_recv_q && !usb_rx_i.valid && usb_rx_i.last &&
                       data_kind_q == DATA1;
  assign rx_end      = rx_beat_end || rx_zero_end;
  assign tx_last     = ctl_tx_i.valid && ctl_tready_i && ctl_tx_i.last;
  assign tok_in      = tok_i.recv && tok_i.kind == TOK_IN;
  // SOF tokens are ignored by the sequencer
  assign tok_out     = tok_i.recv && tok_i.kind == TOK_OUT;

  always_comb begin
    stage_d = stage_q;
    if (!fsm_ctrl_i) begin
      stage_d = CTL_SETUP_RX;
    end else begin
      case (stage_q)
        CTL_SETUP_RX: if (rx_end) stage_d = CTL_SETUP_ACK;
        CTL_SETUP_ACK: begin
          // No data stage for a zero-length request
          if (hsk_sent_i) begin
            stage_d = (req_i.length == 16'd0) ? CTL_STATUS_TOK : CTL_DATA_TOK;
          end
        end
        CTL_DATA_TOK: begin
          // IN after OUT data opens the status stage
          if (tok_in) begin
            stage_d = out_seen_q ? CTL_STATUS_TX : CTL_DATI_TX;
          end else if (tok_out) begin
            stage_d = CTL_DATO_RX;
          end
        end
        CTL_DATO_RX: if (rx_end) stage_d = CTL_DATO_ACK;
        CTL_DATO_ACK: if (hsk_sent_i) stage_d = CTL_DATA_TOK;
        CTL_DATI_TX: if (tx_last) stage_d = CTL_DATI_ACK;
        CTL_DATI_ACK: begin
          // Anything but ACK from the host aborts the transfer
          if (hsk_rx_i.recv && hsk_rx_i.kind == HSK_ACK) begin
            stage_d = CTL_STATUS_TOK;
          end else if (hsk_rx_i.recv || tok_i.recv) begin
            stage_d = CTL_DONE;
          end
        end
        CTL_STATUS_TOK: begin
          if (tok_in) begin
            stage_d = CTL_STATUS_TX;
          end else if (tok_out) begin
            stage_d = CTL_STATUS_RX;
          end
        end
        CTL_STATUS_RX: if (rx_end) stage_d = CTL_STATUS_ACK;
        // Empty DATA1 accepted by the issuer
        CTL_STATUS_TX: if (data_taken_i) stage_d = CTL_STATUS_ACK;
        CTL_STATUS_ACK: if (hsk_rx_i.recv || hsk_sent_i) stage_d = CTL_DONE;
        CTL_DONE: if (fsm_idle_i) stage_d = CTL_SETUP_RX;
        default: stage_d = CTL_SETUP_RX;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_q     <= CTL_SETUP_RX;
      odd_q       <= 1'b0;
      out_seen_q  <= 1'b0;
      tx_issued_q <= 1'b0;
    end else begin
      stage_q <= stage_d;
      // One data request per transmit stage
      if (stage_d != stage_q) begin
        tx_issued_q <= 1'b0;
      end else if (pkt_req.data_req) begin
        tx_issued_q <= 1'b1;
      end
      // Data stage starts on DATA1, status stage is always DATA1
      if (stage_q == CTL_SETUP_ACK || stage_d == CTL_STATUS_TOK ||
          stage_d == CTL_STATUS_TX) begin
        odd_q <= 1'b1;
      end else if (stage_q == CTL_DATO_ACK && stage_d == CTL_DATA_TOK) begin
        odd_q <= ~odd_q;
      end
      // Remember the direction of the data stage
      if (stage_q == CTL_SETUP_ACK) begin
        out_seen_q <= 1'b0;
      end else if (stage_q == CTL_DATO_ACK && stage_d == CTL_DATA_TOK) begin
        out_seen_q <= 1'b1;
      end
    end
  end

  assign rx_stage = stage_q inside {CTL_SETUP_RX, CTL_DATO_RX, CTL_STATUS_RX};

  always_comb begin
    // ACK every packet we receive
    pkt_req.hsk_req  = fsm_ctrl_i && !fsm_idle_i && rx_stage && rx_end;
    // IN data on the first handler beat, status IN carries no payload
    pkt_req.data_req = fsm_ctrl_i && !tx_issued_q &&
                       ((stage_q == CTL_DATI_TX && ctl_tx_i.valid) ||
                        stage_q == CTL_STATUS_TX);
    pkt_req.zero_len = stage_q == CTL_STATUS_TX;
    pkt_req.kind     = odd_q ? DATA1 : DATA0;
  end

  assign pkt_req_o      = pkt_req;
  assign setup_active_o = stage_q == CTL_SETUP_RX;
  assign stage_done_o   = stage_q == CTL_DONE;

endmodule

/* verilog/packet_issuer.sv */
`timescale 1ns/1ns

module packet_issuer import usb_pid_pkg::*, ctl_xfer_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  pkt_req_s  pkt_req_i,
  input  logic      hsk_sent_i,
  input  logic      usb_busy_i,
  output logic      data_taken_o,
  output logic      hsk_send_o,
  output hsk_type_e hsk_type_o,
  output logic      usb_send_o,
  output data_pid_e usb_type_o
);

  logic      hsk_send_q;
  logic      usb_send_q;
  data_pid_e usb_type_q;
  logic      data_taken_q;

  // Send flags stay up until the encoder answers
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_q   <= 1'b0;
      usb_send_q   <= 1'b0;
      data_taken_q <= 1'b0;
    end else begin
      data_taken_q <= 1'b0;
      if (hsk_send_q) begin
        if (hsk_sent_i) hsk_send_q <= 1'b0;
      end else if (pkt_req_i.hsk_req) begin
        hsk_send_q <= 1'b1;
      end
      // Busy means the encoder has picked up the data packet
      if (usb_busy_i) begin
        usb_send_q <= 1'b0;
      end else if (!usb_send_q && pkt_req_i.data_req) begin
        usb_send_q   <= 1'b1;
        data_taken_q <= pkt_req_i.zero_len;
      end
    end
  end

  // Data kind latched with its request
  always_ff @(posedge clock) begin
    if (!usb_send_q && !usb_busy_i && pkt_req_i.data_req) usb_type_q <= pkt_req_i.kind;
  end

  assign hsk_send_o   = hsk_send_q;
  // The engine only ever answers received packets with ACK
  assign hsk_type_o   = HSK_ACK;
  assign usb_send_o   = usb_send_q;
  assign usb_type_o   = usb_type_q;
  assign data_taken_o = data_taken_q;

endmodule

/* verilog/control_transfer_top.sv */
`timescale 1ns/1ns

module control_transfer_top import usb_pid_pkg::*, ctl_xfer_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         fsm_ctrl_i,
  input  logic         fsm_idle_i,
  // From the packet decoder
  input  tok_s         tok_i,
  input  hsk_rx_s      hsk_rx_i,
  input  data_rx_s     data_rx_i,
  input  byte_stream_s usb_rx_i,
  // From the packet encoder
  input  logic         hsk_sent_i,
  input  logic         usb_busy_i,
  input  logic         usb_sent_i,
  // IN data from the request handler, out to the encoder
  input  byte_stream_s ctl_tx_i,
  output logic         ctl_tready_o,
  output byte_stream_s usb_tx_o,
  input  logic         usb_tready_i,
  // Request to the handler
  output setup_req_s   ctl_req_o,
  output logic         ctl_start_o,
  output logic         ctl_cycle_o,
  output logic         ctl_done_o,
  // Send requests to the encoder
  output logic         hsk_send_o,
  output hsk_type_e    hsk_type_o,
  output logic         usb_send_o,
  output data_pid_e    usb_type_o
);

  setup_req_s req;
  logic       setup_active;
  pkt_req_s   pkt_req;
  logic       data_taken;

  // IN data goes straight through, back-pressure included
  assign usb_tx_o     = ctl_tx_i;
  assign ctl_tready_o = usb_tready_i;
  assign ctl_req_o    = req;

  setup_parser i_setup_parser (
    .clock          (clock),
    .reset          (reset),
    .fsm_idle_i     (fsm_idle_i),
    .setup_active_i (setup_active),
    .usb_rx_i       (usb_rx_i),
    .ctl_tx_i       (ctl_tx_i),
    .ctl_tready_i   (usb_tready_i),
    .req_o          (req),
    .start_o        (ctl_start_o),
    .cycle_o        (ctl_cycle_o)
  );

  ctl_stage_fsm i_ctl_stage_fsm (
    .clock          (clock),
    .reset          (reset),
    .fsm_ctrl_i     (fsm_ctrl_i),
    .fsm_idle_i     (fsm_idle_i),
    .req_i          (req),
    .tok_i          (tok_i),
    .hsk_rx_i       (hsk_rx_i),
    .hsk_sent_i     (hsk_sent_i),
    .data_rx_i      (data_rx_i),
    .usb_rx_i       (usb_rx_i),
    .ctl_tx_i       (ctl_tx_i),
    .ctl_tready_i   (usb_tready_i),
    .data_taken_i   (data_taken),
    .setup_active_o (setup_active),
    .stage_done_o   (ctl_done_o),
    .pkt_req_o      (pkt_req)
  );

  packet_issuer i_packet_issuer (
    .clock        (clock),
    .reset        (reset),
    .pkt_req_i    (pkt_req),
    .hsk_sent_i   (hsk_sent_i),
    .usb_busy_i   (usb_busy_i),
    .data_taken_o (data_taken),
    .hsk_send_o   (hsk_send_o),
    .hsk_type_o   (hsk_type_o),
    .usb_send_o   (usb_send_o),
    .usb_type_o   (usb_type_o)
  );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clock_o,
  output logic reset_o
);

  // 40 ns period, first rising edge at 20 ns
  initial begin
    clock_o = 1'b0;
    forever #20 clock_o = ~clock_o;
  end

  // Reset held over four rising edges, dropped between edges
  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clock_o);
    #10 reset_o = 1'b0;
  end

endmodule

/* verification/tb_top.sv */
`timescale 1ns/1ns

module tb_top import usb_pid_pkg::*, ctl_xfer_pkg::*; ();

  localparam int WAIT_LIMIT     = 32;
  localparam int FLAG_USB_SEND  = 0;
  localparam int FLAG_DONE      = 1;
  localparam int FLAG_RESET_LOW = 2;

  logic         clock;
  logic         reset;
  logic         fsm_ctrl_i;
  logic         fsm_idle_i;
  tok_s         tok_i;
  hsk_rx_s      hsk_rx_i;
  data_rx_s     data_rx_i;
  byte_stream_s usb_rx_i;
  logic         hsk_sent_i;
  logic         usb_busy_i;
  logic         usb_sent_i;
  byte_stream_s ctl_tx_i;
  logic         ctl_tready_o;
  byte_stream_s usb_tx_o;
  logic         usb_tready_i;
  setup_req_s   ctl_req_o;
  logic         ctl_start_o;
  logic         ctl_cycle_o;
  logic         ctl_done_o;
  logic         hsk_send_o;
  hsk_type_e    hsk_type_o;
  logic         usb_send_o;
  data_pid_e    usb_type_o;

  // Test state
  logic [31:0] seed;
  logic [7:0]  pkt_bytes [8];
  setup_req_s  exp_req;
  logic        start_early;
  int          errors;
  int          checks;
  int          err_base;

  tb_clock i_clock (.clock_o(clock), .reset_o(reset));

  control_transfer_top i_dut (.*);

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic flag_value(input int sel);
    case (sel)
      FLAG_USB_SEND: return usb_send_o;
      FLAG_DONE:     return ctl_done_o;
      default:       return !reset;
    endcase
  endfunction

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    assert (actual === expected) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Bounded wait on one DUT flag sampled on falling edges
  task automatic wait_flag(input int sel, input string name);
    int  n;
    logic seen;
    n = 0;
    seen = flag_value(sel) === 1'b1;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
      seen = flag_value(sel) === 1'b1;
    end
    assert (seen) else begin
      $display("at %0t: %s never went high within %0d cycles", $time, name, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s finished with %0d errors", name, errors - err_base);
  endtask

  task automatic fill_bytes();
    for (int i = 0; i < 8; i++) begin
      seed = next_random(seed);
      pkt_bytes[i] = seed[23:16];
    end
  endtask

  task automatic pulse_token(input tok_type_e kind);
    @(negedge clock);
    tok_i = {1'b1, kind, 7'd0, 4'd0};
    @(negedge clock);
    tok_i = '0;
  endtask

  task automatic host_hsk(input hsk_type_e kind);
    @(negedge clock);
    hsk_rx_i = {1'b1, kind};
    @(negedge clock);
    hsk_rx_i = '0;
  endtask

  // Encoder answers with hsk_sent and busy pulses
  task automatic encoder_ack(input logic hsk, input logic busy);
    @(negedge clock);
    hsk_sent_i = hsk;
    usb_busy_i = busy;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    usb_busy_i = 1'b0;
  endtask

  task automatic rearm();
    @(negedge clock);
    fsm_idle_i = 1'b1;
    @(negedge clock);
    fsm_idle_i = 1'b0;
  endtask

  // Data header then n payload bytes or a bare last when n is zero
  task automatic rx_packet(input data_pid_e kind, input int n);
    start_early = 1'b0;
    @(negedge clock);
    data_rx_i = {1'b1, kind};
    for (int i = 0; i < n; i++) begin
      @(negedge clock);
      start_early = start_early | ctl_start_o;
      data_rx_i = '0;
      usb_rx_i = {1'b1, i == n - 1, pkt_bytes[i]};
    end
    if (n == 0) begin
      @(negedge clock);
      data_rx_i = '0;
      usb_rx_i = {1'b0, 1'b1, 8'h00};
    end
    @(negedge clock);
    usb_rx_i = '0;
  endtask

  // SETUP token and DATA0 payload with forced length bytes
  task automatic send_setup(input logic [15:0] len);
    fill_bytes();
    pkt_bytes[6] = len[7:0];
    pkt_bytes[7] = len[15:8];
    exp_req = {pkt_bytes[0], pkt_bytes[1], pkt_bytes[3], pkt_bytes[2],
               pkt_bytes[5], pkt_bytes[4], pkt_bytes[7], pkt_bytes[6]};
    pulse_token(TOK_SETUP);
    rx_packet(DATA0, 8);
    check_equal("ctl_start_o early", 64'(start_early), 64'd0);
    check_equal("ctl_start_o", 64'(ctl_start_o), 64'd1);
    check_equal("ctl_req_o", 64'(ctl_req_o), 64'(exp_req));
    check_equal("hsk_send_o", 64'(hsk_send_o), 64'd1);
    check_equal("hsk_type_o", 64'(hsk_type_o), 64'(HSK_ACK));
    @(negedge clock);
    check_equal("ctl_start_o", 64'(ctl_start_o), 64'd0);
  endtask

  // Handler IN beats with the second beat stalled one cycle by the encoder
  task automatic stream_in(input int n);
    byte_stream_s beat;
    for (int i = 0; i < n; i++) begin
      seed = next_random(seed);
      beat = {1'b1, i == n - 1, seed[23:16]};
      for (int k = (i == 1) ? 0 : 1; k < 2; k++) begin
        @(negedge clock);
        check_equal("ctl_cycle_o", 64'(ctl_cycle_o), 64'd1);
        ctl_tx_i = beat;
        usb_tready_i = k == 1;
        // Pass-through is combinational and steady by the rising edge
        @(posedge clock);
        check_equal("usb_tx_o", 64'(usb_tx_o), 64'(beat));
        check_equal("ctl_tready_o", 64'(ctl_tready_o), 64'(k == 1));
      end
    end
    @(negedge clock);
    ctl_tx_i = '0;
    check_equal("ctl_cycle_o", 64'(ctl_cycle_o), 64'd0);
  endtask

  task automatic after_reset();
    err_base = errors;
    check_equal("ctl_start_o", 64'(ctl_start_o), 64'd0);
    check_equal("ctl_cycle_o", 64'(ctl_cycle_o), 64'd0);
    check_equal("hsk_send_o", 64'(hsk_send_o), 64'd0);
    check_equal("usb_send_o", 64'(usb_send_o), 64'd0);
    check_equal("ctl_done_o", 64'(ctl_done_o), 64'd0);
    check_equal("ctl_req_o", 64'(ctl_req_o), 64'd0);
    report_test("reset state");
  endtask

  task automatic no_data_transfer();
    err_base = errors;
    send_setup(16'd0);
    encoder_ack(1'b1, 1'b0);
    pulse_token(TOK_IN);
    wait_flag(FLAG_USB_SEND, "usb_send_o");
    check_equal("usb_type_o", 64'(usb_type_o), 64'(DATA1));
    encoder_ack(1'b0, 1'b1);
    host_hsk(HSK_ACK);
    wait_flag(FLAG_DONE, "ctl_done_o");
    rearm();
    report_test("no-data transfer");
  endtask

  task automatic control_read();
    err_base = errors;
    send_setup(16'd3);
    encoder_ack(1'b1, 1'b0);
    pulse_token(TOK_IN);
    stream_in(3);
    // Send request still held because the encoder is not busy yet
    check_equal("usb_send_o", 64'(usb_send_o), 64'd1);
    check_equal("usb_type_o", 64'(usb_type_o), 64'(DATA1));
    encoder_ack(1'b0, 1'b1);
    host_hsk(HSK_ACK);
    pulse_token(TOK_OUT);
    rx_packet(DATA1, 0);
    check_equal("hsk_send_o", 64'(hsk_send_o), 64'd1);
    check_equal("hsk_type_o", 64'(hsk_type_o), 64'(HSK_ACK));
    encoder_ack(1'b1, 1'b0);
    wait_flag(FLAG_DONE, "ctl_done_o");
    rearm();
    report_test("control read");
  endtask

  task automatic control_write();
    err_base = errors;
    send_setup(16'd16);
    encoder_ack(1'b1, 1'b0);
    for (int p = 0; p < 2; p++) begin
      pulse_token(TOK_OUT);
      fill_bytes();
      rx_packet((p == 0) ? DATA1 : DATA0, 4);
      check_equal("hsk_send_o", 64'(hsk_send_o), 64'd1);
      check_equal("hsk_type_o", 64'(hsk_type_o), 64'(HSK_ACK));
      encoder_ack(1'b1, 1'b0);
    end
    // OUT payload must not touch the request record
    check_equal("ctl_req_o", 64'(ctl_req_o), 64'(exp_req));
    pulse_token(TOK_IN);
    wait_flag(FLAG_USB_SEND, "usb_send_o");
    check_equal("usb_type_o", 64'(usb_type_o), 64'(DATA1));
    encoder_ack(1'b0, 1'b1);
    host_hsk(HSK_ACK);
    wait_flag(FLAG_DONE, "ctl_done_o");
    rearm();
    report_test("control write");
  endtask

  task automatic abort_and_rearm();
    err_base = errors;
    send_setup(16'd8);
    encoder_ack(1'b1, 1'b0);
    pulse_token(TOK_IN);
    stream_in(2);
    encoder_ack(1'b0, 1'b1);
    host_hsk(HSK_NAK);
    wait_flag(FLAG_DONE, "ctl_done_o");
    // Aborted transfer ignores a status IN token
    pulse_token(TOK_IN);
    repeat (3) begin
      @(negedge clock);
      check_equal("ctl_done_o", 64'(ctl_done_o), 64'd1);
      check_equal("usb_send_o", 64'(usb_send_o), 64'd0);
      check_equal("hsk_send_o", 64'(hsk_send_o), 64'd0);
    end
    rearm();
    check_equal("ctl_done_o", 64'(ctl_done_o), 64'd0);
    check_equal("ctl_cycle_o", 64'(ctl_cycle_o), 64'd0);
    send_setup(16'h0123);
    encoder_ack(1'b1, 1'b0);
    // Disabled engine gives a received packet no ACK
    @(negedge clock);
    fsm_ctrl_i = 1'b0;
    pulse_token(TOK_SETUP);
    fill_bytes();
    rx_packet(DATA0, 8);
    check_equal("hsk_send_o", 64'(hsk_send_o), 64'd0);
    @(negedge clock);
    fsm_ctrl_i = 1'b1;
    rearm();
    report_test("abort and re-arm");
  endtask

  initial begin
    fsm_ctrl_i   = 1'b1;
    fsm_idle_i   = 1'b0;
    tok_i        = '0;
    hsk_rx_i     = '0;
    data_rx_i    = '0;
    usb_rx_i     = '0;
    hsk_sent_i   = 1'b0;
    usb_busy_i   = 1'b0;
    usb_sent_i   = 1'b0;
    ctl_tx_i     = '0;
    usb_tready_i = 1'b1;
    seed         = 32'd82;
    errors       = 0;
    checks       = 0;
    err_base     = 0;
    wait_flag(FLAG_RESET_LOW, "reset release");
    @(negedge clock);
    after_reset();
    no_data_transfer();
    control_read();
    control_write();
    abort_and_rearm();
    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* sources.f */
verilog/usb_pid_pkg.sv
verilog/ctl_xfer_pkg.sv
verilog/setup_parser.sv
verilog/ctl_stage_fsm.sv
verilog/packet_issuer.sv
verilog/control_transfer_top.sv
verification/tb_clock.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f sources.f \
  || exit 1
out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1
